//--- conv_row_pkg.sv
package conv_row_pkg;

  //////////////////////////////////////////////////
  // Layer configuration
  //////////////////////////////////////////////////

  typedef struct packed {
    logic [3:0]  s;
    logic [3:0]  p;
    logic [3:0]  nif_in_2pow;
    logic [3:0]  ix_in_2pow;
    logic [3:0]  slab_num;
    logic [3:0]  ky_num;
    logic [7:0]  tile_num;
    logic [15:0] iy;
    logic [15:0] poy;
    logic [15:0] iy_start_base;
    logic [15:0] if_start;
    logic [15:0] row_base;
    logic [15:0] row_start_idx;
    logic [15:0] row_slab_start_idx;
  } layer_cfg_t;

  // One step of the tile / kernel-row walk
  typedef struct packed {
    logic [15:0] ky;
    logic [15:0] iy_start;
    logic [15:0] row_base_in_3s;
    logic        last;
  } row_req_t;

  // Translated row addresses
  typedef struct packed {
    logic        hit;
    logic [15:0] row_idx;
    logic [15:0] buf_adr;
    logic [1:0]  buf_idx;
    logic        buf_word_select;
    logic [15:0] slab_adr;
    logic [1:0]  slab_idx;
    logic [15:0] slab_adr_to_wr;
    logic [1:0]  slab_idx_to_wr;
    logic        last;
  } row_adr_t;

  //////////////////////////////////////////////////
  // Register byte offsets
  //////////////////////////////////////////////////

  localparam logic [7:0] reg_ctrl   = 8'h00;
  localparam logic [7:0] reg_status = 8'h04;
  localparam logic [7:0] reg_geom   = 8'h08;
  localparam logic [7:0] reg_iy     = 8'h0C;
  localparam logic [7:0] reg_start  = 8'h10;
  localparam logic [7:0] reg_rows   = 8'h14;
  localparam logic [7:0] reg_slab   = 8'h18;
  localparam logic [7:0] reg_count  = 8'h1C;

endpackage

//--- conv_row_cfg_regs.sv
`timescale 1ns/1ps

module conv_row_cfg_regs (
  input  logic                     clk,
  input  logic                     rst_n,
  // AXI4-Lite slave
  input  logic [7:0]               awaddr,
  input  logic                     awvalid,
  output logic                     awready,
  input  logic [31:0]              wdata,
  input  logic [3:0]               wstrb,
  input  logic                     wvalid,
  output logic                     wready,
  output logic [1:0]               bresp,
  output logic                     bvalid,
  input  logic                     bready,
  input  logic [7:0]               araddr,
  input  logic                     arvalid,
  output logic                     arready,
  output logic [31:0]              rdata,
  output logic [1:0]               rresp,
  output logic                     rvalid,
  input  logic                     rready,
  // Status from the result queue
  input  logic [15:0]              count,
  input  logic                     done,
  output conv_row_pkg::layer_cfg_t cfg,
  output logic                     start
);

  logic        wr_fire;
  logic        rd_fire;
  logic [31:0] geom_q;
  logic [31:0] iy_q;
  logic [31:0] start_q;
  logic [31:0] rows_q;
  logic [31:0] slab_q;
  logic        start_pend;
  logic        busy_q;
  logic        done_q;
  logic [31:0] rd_word;

  // Byte lanes of a write
  function automatic logic [31:0] merge_strb(input logic [31:0] old_word,
                                             input logic [31:0] new_word,
                                             input logic [3:0]  strb);
    logic [31:0] word;
    word = old_word;
    for (int i = 0; i < 4; i++) begin
      if (strb[i]) begin
        word[8*i +: 8] = new_word[8*i +: 8];
      end
    end
    return word;
  endfunction

  // AW and W are taken together
  assign wr_fire = awvalid && wvalid && !bvalid;
  assign awready = wr_fire;
  assign wready  = wr_fire;
  assign bresp   = 2'b00;

  assign arready = arvalid && !rvalid;
  assign rd_fire = arready;
  assign rresp   = 2'b00;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      geom_q     <= '0;
      iy_q       <= '0;
      start_q    <= '0;
      rows_q     <= '0;
      slab_q     <= '0;
      bvalid     <= 1'b0;
      rvalid     <= 1'b0;
      start_pend <= 1'b0;
      start      <= 1'b0;
      busy_q     <= 1'b0;
      done_q     <= 1'b0;
    end else begin
      start <= 1'b0;
      if (wr_fire) begin
        bvalid <= 1'b1;
        case (awaddr)
          conv_row_pkg::reg_ctrl:  start_pend <= wstrb[0] && wdata[0];
          conv_row_pkg::reg_geom:  geom_q  <= merge_strb(geom_q, wdata, wstrb);
          conv_row_pkg::reg_iy:    iy_q    <= merge_strb(iy_q, wdata, wstrb);
          conv_row_pkg::reg_start: start_q <= merge_strb(start_q, wdata, wstrb);
          conv_row_pkg::reg_rows:  rows_q  <= merge_strb(rows_q, wdata, wstrb);
          conv_row_pkg::reg_slab:  slab_q  <= merge_strb(slab_q, wdata, wstrb);
          default: ;
        endcase
      end else if (bvalid && bready) begin
        bvalid     <= 1'b0;
        // Launch once the write response has gone out
        start      <= start_pend;
        start_pend <= 1'b0;
      end
      if (rd_fire) begin
        rvalid <= 1'b1;
      end else if (rvalid && rready) begin
        rvalid <= 1'b0;
      end
      // Sticky status
      if (start) begin
        busy_q <= 1'b1;
        done_q <= 1'b0;
      end else if (done) begin
        busy_q <= 1'b0;
        done_q <= 1'b1;
      end
    end
  end

  always_comb begin
    case (araddr)
      conv_row_pkg::reg_status: rd_word = {30'b0, done_q, busy_q};
      conv_row_pkg::reg_geom:   rd_word = geom_q;
      conv_row_pkg::reg_iy:     rd_word = iy_q;
      conv_row_pkg::reg_start:  rd_word = start_q;
      conv_row_pkg::reg_rows:   rd_word = rows_q;
      conv_row_pkg::reg_slab:   rd_word = slab_q;
      conv_row_pkg::reg_count:  rd_word = {16'b0, count};
      default:                  rd_word = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rd_fire) begin
      rdata <= rd_word;
    end
  end

  //////////////////////////////////////////////////
  // Layer configuration fields
  //////////////////////////////////////////////////

  always_comb begin
    cfg.s                  = geom_q[3:0];
    cfg.p                  = geom_q[7:4];
    cfg.nif_in_2pow        = geom_q[11:8];
    cfg.ix_in_2pow         = geom_q[15:12];
    cfg.slab_num           = geom_q[19:16];
    cfg.ky_num             = geom_q[23:20];
    cfg.tile_num           = geom_q[31:24];
    cfg.iy                 = iy_q[15:0];
    cfg.poy                = iy_q[31:16];
    cfg.iy_start_base      = start_q[15:0];
    cfg.if_start           = start_q[31:16];
    cfg.row_base           = rows_q[15:0];
    cfg.row_start_idx      = rows_q[31:16];
    cfg.row_slab_start_idx = slab_q[15:0];
  end

endmodule

//--- conv_row_sequencer.sv
`timescale 1ns/1ps

module conv_row_sequencer (
  input  logic                     clk,
  input  logic                     rst_n,
  input  conv_row_pkg::layer_cfg_t cfg,
  input  logic                     start,
  output conv_row_pkg::row_req_t   req,
  output logic                     req_valid,
  input  logic                     req_ready
);

  logic [7:0]  tile_q;
  logic [3:0]  ky_q;
  logic [15:0] iy_start_q;
  logic        active_q;
  logic        ky_end;
  logic        tile_end;
  logic        step;

  assign ky_end   = (ky_q == cfg.ky_num - 4'd1);
  assign tile_end = (tile_q == cfg.tile_num - 8'd1);
  assign step     = active_q && req_ready;

  // Request fields follow the loop indices
  assign req.ky             = {12'b0, ky_q};
  assign req.iy_start       = iy_start_q;
  assign req.row_base_in_3s = cfg.row_base + {8'b0, tile_q};
  assign req.last           = ky_end && tile_end;
  assign req_valid          = active_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      active_q   <= 1'b0;
      tile_q     <= '0;
      ky_q       <= '0;
      iy_start_q <= '0;
    end else if (start) begin
      active_q   <= 1'b1;
      tile_q     <= '0;
      ky_q       <= '0;
      iy_start_q <= cfg.iy_start_base;
    end else if (step) begin
      if (req.last) begin
        active_q <= 1'b0;
      end else if (ky_end) begin
        // Next tile moves down by poy rows
        ky_q       <= '0;
        tile_q     <= tile_q + 8'd1;
        iy_start_q <= iy_start_q + cfg.poy;
      end else begin
        ky_q <= ky_q + 4'd1;
      end
    end
  end

endmodule

//--- conv_row_translate.sv
`timescale 1ns/1ps

module conv_row_translate #(
  parameter int pixels_in_row_2pow  = 5,
  parameter int ifs_in_row_2pow     = 1,
  parameter int input_buf_size_2pow = 12,
  parameter int slab_buf_size_2pow  = 13
) (
  input  logic                     clk,
  input  logic                     rst_n,
  input  conv_row_pkg::layer_cfg_t cfg,
  input  conv_row_pkg::row_req_t   req,
  input  logic                     req_valid,
  output logic                     req_ready,
  output conv_row_pkg::row_adr_t   res,
  output logic                     res_valid,
  input  logic                     res_ready
);

  localparam logic [3:0] pix_sh = 4'(pixels_in_row_2pow);
  localparam logic [3:0] ifs_sh = 4'(ifs_in_row_2pow);
  localparam logic [3:0] in_sz  = 4'(input_buf_size_2pow);
  localparam logic [3:0] sl_sz  = 4'(slab_buf_size_2pow);

  logic advance;
  // Stage 1 combinational
  logic [15:0] p16, s16, r, bias0, bias, base;
  logic        wrap, miss;
  logic [15:0] idx16;
  logic [1:0]  off;
  // Stage 1 registers
  logic        s1_valid, s1_miss, s1_last;
  logic [15:0] s1_row_idx, s1_base;
  logic [1:0]  s1_off, s1_idx;
  // Stage 2 combinational
  logic [3:0]  if_sh, in_inner, in_lim, sl_inner, sl_lim;
  logic [15:0] in_mask, sl_mask, in_row, if_m1;
  logic [15:0] rsi_in, rsi_sl, rssi_sl;
  conv_row_pkg::row_adr_t nxt;

  assign advance   = !res_valid || res_ready;
  assign req_ready = advance;

  //////////////////////////////////////////////////
  // Stage 1 row, bias and buffer index
  //////////////////////////////////////////////////

  always_comb begin
    p16   = {12'b0, cfg.p};
    s16   = {12'b0, cfg.s};
    r     = req.ky + req.iy_start + s16;
    miss  = (cfg.poy < 16'd2) || (r < p16 + 16'd1) || (r > p16 + cfg.iy);
    bias0 = r - p16 - req.row_base_in_3s - (req.row_base_in_3s << 1);
    // Zero or negative bias belongs to the previous group of three
    wrap  = bias0[15] || (bias0 == 16'd0);
    base  = wrap ? req.row_base_in_3s - 16'd1 : req.row_base_in_3s;
    bias  = wrap ? bias0 + s16 + (s16 << 1) : bias0;
    if (bias <= 16'd3) begin
      idx16 = bias;
      off   = 2'd0;
    end else if (bias <= 16'd6) begin
      idx16 = bias - 16'd3;
      off   = 2'd1;
    end else if (bias <= 16'd9) begin
      idx16 = bias - 16'd6;
      off   = 2'd2;
    end else begin
      idx16 = bias - 16'd9;
      off   = 2'd3;
    end
  end

  always_ff @(posedge clk) begin
    if (advance) begin
      s1_miss    <= miss;
      s1_last    <= req.last;
      s1_row_idx <= miss ? 16'hFFFF : r - p16;
      s1_base    <= base;
      s1_off     <= off;
      s1_idx     <= idx16[1:0];
    end
  end

  //////////////////////////////////////////////////
  // Stage 2 address mapping
  //////////////////////////////////////////////////

  always_comb begin
    if_sh    = cfg.nif_in_2pow - ifs_sh;
    in_inner = if_sh + cfg.ix_in_2pow - pix_sh;
    in_lim   = in_sz - in_inner;
    sl_inner = cfg.nif_in_2pow + cfg.ix_in_2pow - pix_sh;
    sl_lim   = sl_sz - sl_inner;
    // Power-of-two row masks
    in_mask  = 16'hFFFF >> (16 - int'(in_lim));
    sl_mask  = 16'hFFFF >> (16 - int'(sl_lim));
    case (cfg.s)
      4'd1:    in_row = s1_base + {14'b0, s1_off};
      4'd2:    in_row = (s1_base << 1) + {14'b0, s1_off};
      default: in_row = '0;
    endcase
    if_m1   = cfg.if_start - 16'd1;
    rsi_in  = cfg.row_start_idx << if_sh;
    rsi_sl  = cfg.row_start_idx << cfg.nif_in_2pow;
    rssi_sl = cfg.row_slab_start_idx << cfg.nif_in_2pow;

    nxt.hit             = !s1_miss;
    nxt.row_idx         = s1_row_idx;
    nxt.buf_word_select = if_m1[0];
    nxt.last            = s1_last;
    if (s1_miss) begin
      nxt.buf_adr        = 16'hFFFF;
      nxt.buf_idx        = 2'd0;
      nxt.slab_adr_to_wr = 16'hFFFF;
      nxt.slab_idx_to_wr = 2'd0;
    end else begin
      nxt.buf_adr        = ((in_row & in_mask) << in_inner) + (rsi_in >> pix_sh)
                           + (if_m1 >> ifs_sh);
      nxt.buf_idx        = s1_idx;
      nxt.slab_adr_to_wr = ((in_row & sl_mask) << sl_inner) + (rsi_sl >> pix_sh) + if_m1;
      nxt.slab_idx_to_wr = s1_idx;
    end
    if (s1_miss || cfg.slab_num == 4'd0) begin
      nxt.slab_adr = 16'hFFFF;
      nxt.slab_idx = 2'd0;
    end else begin
      nxt.slab_adr = ((in_row & sl_mask) << sl_inner) + (rssi_sl >> pix_sh) + if_m1;
      nxt.slab_idx = s1_idx;
    end
  end

  always_ff @(posedge clk) begin
    if (advance) begin
      res <= nxt;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      s1_valid  <= 1'b0;
      res_valid <= 1'b0;
    end else if (advance) begin
      s1_valid  <= req_valid;
      res_valid <= s1_valid;
    end
  end

endmodule

//--- conv_row_result.sv
`timescale 1ns/1ps

module conv_row_result #(
  parameter int fifo_depth = 4
) (
  input  logic                   clk,
  input  logic                   rst_n,
  input  conv_row_pkg::row_adr_t res,
  input  logic                   res_valid,
  output logic                   res_ready,
  output conv_row_pkg::row_adr_t out_data,
  output logic                   out_valid,
  input  logic                   out_ready,
  output logic [15:0]            count,
  output logic                   done
);

  localparam int aw = (fifo_depth > 1) ? $clog2(fifo_depth) : 1;

  conv_row_pkg::row_adr_t mem [fifo_depth];
  logic [aw-1:0] wr_ptr, rd_ptr;
  logic [aw:0]   used;
  logic          wr, rd;
  logic          done_seen;

  assign res_ready = (used != fifo_depth[aw:0]);
  assign out_valid = (used != '0);
  assign out_data  = mem[rd_ptr];
  assign wr        = res_valid && res_ready;
  assign rd        = out_valid && out_ready;

  always_ff @(posedge clk) begin
    if (wr) begin
      mem[wr_ptr] <= res;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr    <= '0;
      rd_ptr    <= '0;
      used      <= '0;
      count     <= '0;
      done      <= 1'b0;
      done_seen <= 1'b0;
    end else begin
      if (wr) begin
        wr_ptr <= (wr_ptr == aw'(fifo_depth - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (rd) begin
        rd_ptr <= (rd_ptr == aw'(fifo_depth - 1)) ? '0 : rd_ptr + 1'b1;
      end
      used <= used + (aw+1)'(wr) - (aw+1)'(rd);
      // First write of a new run restarts the count
      if (wr && done_seen) begin
        count     <= rd ? 16'd1 : 16'd0;
        done_seen <= 1'b0;
      end else if (rd) begin
        count <= count + 16'd1;
      end
      done <= rd && out_data.last;
      if (done) begin
        done_seen <= 1'b1;
      end
    end
  end

endmodule

//--- conv_row_top.sv
`timescale 1ns/1ps

module conv_row_top #(
  parameter int pixels_in_row_2pow  = 5,
  parameter int ifs_in_row_2pow     = 1,
  parameter int input_buf_size_2pow = 12,
  parameter int slab_buf_size_2pow  = 13,
  parameter int fifo_depth          = 4
) (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic [7:0]             awaddr,
  input  logic                   awvalid,
  output logic                   awready,
  input  logic [31:0]            wdata,
  input  logic [3:0]             wstrb,
  input  logic                   wvalid,
  output logic                   wready,
  output logic [1:0]             bresp,
  output logic                   bvalid,
  input  logic                   bready,
  input  logic [7:0]             araddr,
  input  logic                   arvalid,
  output logic                   arready,
  output logic [31:0]            rdata,
  output logic [1:0]             rresp,
  output logic                   rvalid,
  input  logic                   rready,
  output conv_row_pkg::row_adr_t out_data,
  output logic                   out_valid,
  input  logic                   out_ready
);

  conv_row_pkg::layer_cfg_t cfg;
  conv_row_pkg::row_req_t   req;
  conv_row_pkg::row_adr_t   res;
  logic        start, req_valid, req_ready, res_valid, res_ready, done;
  logic [15:0] count;

  conv_row_cfg_regs u_regs (
    .clk, .rst_n,
    .awaddr, .awvalid, .awready, .wdata, .wstrb, .wvalid, .wready,
    .bresp, .bvalid, .bready,
    .araddr, .arvalid, .arready, .rdata, .rresp, .rvalid, .rready,
    .count, .done, .cfg, .start
  );

  // Decode, execute and result
  conv_row_sequencer u_seq (
    .clk, .rst_n, .cfg, .start, .req, .req_valid, .req_ready
  );

  conv_row_translate #(
    .pixels_in_row_2pow (pixels_in_row_2pow),
    .ifs_in_row_2pow    (ifs_in_row_2pow),
    .input_buf_size_2pow(input_buf_size_2pow),
    .slab_buf_size_2pow (slab_buf_size_2pow)
  ) u_xlat (
    .clk, .rst_n, .cfg, .req, .req_valid, .req_ready, .res, .res_valid, .res_ready
  );

  conv_row_result #(
    .fifo_depth(fifo_depth)
  ) u_res (
    .clk, .rst_n, .res, .res_valid, .res_ready,
    .out_data, .out_valid, .out_ready, .count, .done
  );

endmodule

//--- conv_row_tb_clk.sv
`timescale 1ns/1ps

module conv_row_tb_clk #(
  parameter int half_period_ns = 5
) (
  output logic clk
);

  initial begin
    clk = 1'b0;
    forever #(half_period_ns) clk = ~clk;
  end

endmodule

//--- conv_row_tb_ref.svh
`ifndef CONV_ROW_TB_REF_SVH
`define CONV_ROW_TB_REF_SVH

// Expected translation of one row request
function automatic conv_row_pkg::row_adr_t expected_row(input conv_row_pkg::layer_cfg_t c,
                                                        input conv_row_pkg::row_req_t q);
  conv_row_pkg::row_adr_t e;
  logic [15:0] r, bias, base, idx, in_row, if_m1, in_mask, sl_mask;
  logic [15:0] rsi_in, rsi_sl, rssi_sl;
  logic [3:0]  if_sh, in_inner, sl_inner, in_lim, sl_lim;
  logic [1:0]  off;
  logic        miss;
  r    = q.ky + q.iy_start + 16'(c.s);
  miss = (c.poy < 16'd2) || (r < 16'(c.p) + 16'd1) || (r > 16'(c.p) + c.iy);
  bias = r - 16'(c.p) - 16'd3 * q.row_base_in_3s;
  base = q.row_base_in_3s;
  // Non-positive bias falls into the previous group of three rows
  if ($signed(bias) <= 0) begin
    base = base - 16'd1;
    bias = bias + 16'd3 * 16'(c.s);
  end
  idx = bias;
  off = 2'd0;
  while (idx > 16'd3 && off < 2'd3) begin
    idx = idx - 16'd3;
    off = off + 2'd1;
  end
  if_sh    = c.nif_in_2pow - 4'(ifs_2pow);
  in_inner = if_sh + c.ix_in_2pow - 4'(pix_2pow);
  sl_inner = c.nif_in_2pow + c.ix_in_2pow - 4'(pix_2pow);
  in_lim   = 4'(in_size_2pow) - in_inner;
  sl_lim   = 4'(slab_size_2pow) - sl_inner;
  in_mask  = 16'((32'd1 << in_lim) - 32'd1);
  sl_mask  = 16'((32'd1 << sl_lim) - 32'd1);
  if (c.s == 4'd1) begin
    in_row = base + 16'(off);
  end else if (c.s == 4'd2) begin
    in_row = 16'd2 * base + 16'(off);
  end else begin
    in_row = 16'd0;
  end
  if_m1   = c.if_start - 16'd1;
  rsi_in  = c.row_start_idx << if_sh;
  rsi_sl  = c.row_start_idx << c.nif_in_2pow;
  rssi_sl = c.row_slab_start_idx << c.nif_in_2pow;
  e.hit             = !miss;
  e.row_idx         = miss ? 16'hFFFF : r - 16'(c.p);
  e.buf_word_select = if_m1[0];
  e.last            = q.last;
  e.buf_adr         = miss ? 16'hFFFF : ((in_row & in_mask) << in_inner)
                      + (rsi_in >> pix_2pow) + (if_m1 >> ifs_2pow);
  e.buf_idx         = miss ? 2'd0 : idx[1:0];
  e.slab_adr_to_wr  = miss ? 16'hFFFF : ((in_row & sl_mask) << sl_inner)
                      + (rsi_sl >> pix_2pow) + if_m1;
  e.slab_idx_to_wr  = miss ? 2'd0 : idx[1:0];
  e.slab_adr        = (miss || c.slab_num == 4'd0) ? 16'hFFFF
                      : ((in_row & sl_mask) << sl_inner) + (rssi_sl >> pix_2pow) + if_m1;
  e.slab_idx        = (miss || c.slab_num == 4'd0) ? 2'd0 : idx[1:0];
  return e;
endfunction

`endif

//--- conv_row_tb.sv
`timescale 1ns/1ps

module conv_row_tb;

  localparam int pix_2pow       = 5;
  localparam int ifs_2pow       = 1;
  localparam int in_size_2pow   = 12;
  localparam int slab_size_2pow = 13;
  localparam int depth          = 4;
  localparam int n_layers       = 6;

  logic        clk;
  logic        rst_n;
  logic [7:0]  awaddr, araddr;
  logic [31:0] wdata, rdata;
  logic [3:0]  wstrb;
  logic [1:0]  bresp, rresp;
  logic        awvalid, awready, wvalid, wready, bvalid, bready;
  logic        arvalid, arready, rvalid, rready;
  logic        out_valid;
  logic        out_ready = 1'b0;
  conv_row_pkg::row_adr_t   out_data;
  conv_row_pkg::row_adr_t   exp_q[$];
  conv_row_pkg::layer_cfg_t layers[n_layers];
  integer      seed = 94130;
  int          errors = 0;
  int          seen = 0;
  int          watchdog_cycles = 0;
  logic        hold_ready = 1'b0;
  logic        rand_ready = 1'b0;

  `include "conv_row_tb_ref.svh"

  conv_row_tb_clk u_clk (.clk(clk));

  conv_row_top #(
    .pixels_in_row_2pow (pix_2pow),
    .ifs_in_row_2pow    (ifs_2pow),
    .input_buf_size_2pow(in_size_2pow),
    .slab_buf_size_2pow (slab_size_2pow),
    .fifo_depth         (depth)
  ) UUT (
    .clk, .rst_n,
    .awaddr, .awvalid, .awready, .wdata, .wstrb, .wvalid, .wready,
    .bresp, .bvalid, .bready,
    .araddr, .arvalid, .arready, .rdata, .rresp, .rvalid, .rready,
    .out_data, .out_valid, .out_ready
  );

  //////////////////////////////////////////////////
  // AXI4-Lite host
  //////////////////////////////////////////////////

  task automatic axi_write(input logic [7:0] addr, input logic [31:0] data);
    @(negedge clk);
    awaddr  = addr;
    wdata   = data;
    wstrb   = 4'hF;
    awvalid = 1'b1;
    wvalid  = 1'b1;
    bready  = 1'b1;
    do begin
      @(posedge clk);
    end while (!awready);
    @(negedge clk);
    awvalid = 1'b0;
    wvalid  = 1'b0;
    do begin
      @(posedge clk);
    end while (!bvalid);
    if (bresp !== 2'b00) begin
      errors++;
      $display("FAIL bresp: got %h expected %h", bresp, 2'b00);
    end
    @(negedge clk);
    bready = 1'b0;
  endtask

  task automatic axi_read(input logic [7:0] addr, output logic [31:0] data);
    @(negedge clk);
    araddr  = addr;
    arvalid = 1'b1;
    rready  = 1'b1;
    do begin
      @(posedge clk);
    end while (!arready);
    @(negedge clk);
    arvalid = 1'b0;
    do begin
      @(posedge clk);
    end while (!rvalid);
    data = rdata;
    if (rresp !== 2'b00) begin
      errors++;
      $display("FAIL rresp: got %h expected %h", rresp, 2'b00);
    end
    @(negedge clk);
    rready = 1'b0;
  endtask

  task automatic check_reg(input string name, input logic [7:0] addr, input logic [31:0] exp);
    logic [31:0] got;
    axi_read(addr, got);
    if (got !== exp) begin
      errors++;
      $display("FAIL %s: got %h expected %h", name, got, exp);
    end
  endtask

  function automatic logic [31:0] geom_word(input conv_row_pkg::layer_cfg_t c);
    return {c.tile_num, c.ky_num, c.slab_num, c.ix_in_2pow, c.nif_in_2pow, c.p, c.s};
  endfunction

  function automatic conv_row_pkg::layer_cfg_t base_layer();
    conv_row_pkg::layer_cfg_t c;
    c.s                  = 4'd1;
    c.p                  = 4'd1;
    c.nif_in_2pow        = 4'd2;
    c.ix_in_2pow         = 4'd5;
    c.slab_num           = 4'd2;
    c.ky_num             = 4'd3;
    c.tile_num           = 8'd4;
    c.iy                 = 16'd32;
    c.poy                = 16'd4;
    c.iy_start_base      = 16'd4;
    c.if_start           = 16'd3;
    c.row_base           = 16'd2;
    c.row_start_idx      = 16'd1;
    c.row_slab_start_idx = 16'd2;
    return c;
  endfunction

  // One layer: program, predict, start, wait for done
  task automatic run_layer(input int n, input logic rnd);
    conv_row_pkg::layer_cfg_t c;
    conv_row_pkg::row_req_t   q;
    logic [31:0] status;
    int          total;
    c = layers[n];
    axi_write(conv_row_pkg::reg_geom, geom_word(c));
    axi_write(conv_row_pkg::reg_iy, {c.poy, c.iy});
    axi_write(conv_row_pkg::reg_start, {c.if_start, c.iy_start_base});
    axi_write(conv_row_pkg::reg_rows, {c.row_start_idx, c.row_base});
    axi_write(conv_row_pkg::reg_slab, {16'd0, c.row_slab_start_idx});
    check_reg("reg_geom", conv_row_pkg::reg_geom, geom_word(c));
    check_reg("reg_iy", conv_row_pkg::reg_iy, {c.poy, c.iy});
    check_reg("reg_start", conv_row_pkg::reg_start, {c.if_start, c.iy_start_base});
    check_reg("reg_rows", conv_row_pkg::reg_rows, {c.row_start_idx, c.row_base});
    check_reg("reg_slab", conv_row_pkg::reg_slab, {16'd0, c.row_slab_start_idx});
    total = int'(c.tile_num) * int'(c.ky_num);
    for (int t = 0; t < int'(c.tile_num); t++) begin
      for (int k = 0; k < int'(c.ky_num); k++) begin
        q.ky             = 16'(k);
        q.iy_start       = c.iy_start_base + 16'(t) * c.poy;
        q.row_base_in_3s = c.row_base + 16'(t);
        q.last           = (t == int'(c.tile_num) - 1) && (k == int'(c.ky_num) - 1);
        exp_q.push_back(expected_row(c, q));
      end
    end
    seen       = 0;
    @(posedge clk);
    hold_ready = 1'b1;
    rand_ready = rnd;
    axi_write(conv_row_pkg::reg_ctrl, 32'h1);
    // Start pulse and sticky status settle
    repeat (2) @(negedge clk);
    check_reg("reg_status", conv_row_pkg::reg_status, 32'h1);
    @(posedge clk);
    hold_ready = 1'b0;
    do begin
      axi_read(conv_row_pkg::reg_status, status);
    end while (!status[1]);
    check_reg("reg_status", conv_row_pkg::reg_status, 32'h2);
    if (seen != total) begin
      errors++;
      $display("Layer %0d produced %0d outputs where %0d were expected", n, seen, total);
    end
    check_reg("reg_count", conv_row_pkg::reg_count, 32'(total));
  endtask

  //////////////////////////////////////////////////
  // Output side
  //////////////////////////////////////////////////

  always @(negedge clk) begin
    if (hold_ready) begin
      out_ready <= 1'b0;
    end else if (rand_ready) begin
      out_ready <= ($random(seed) & 3) != 0;
    end else begin
      out_ready <= 1'b1;
    end
  end

  task automatic check_field(input string name, input logic [15:0] got, input logic [15:0] exp);
    if (got !== exp) begin
      errors++;
      $display("FAIL out_data.%s entry %0d: got %h expected %h", name, seen, got, exp);
    end
  endtask

  task automatic check_entry(input conv_row_pkg::row_adr_t got, input conv_row_pkg::row_adr_t exp);
    check_field("hit", 16'(got.hit), 16'(exp.hit));
    check_field("row_idx", got.row_idx, exp.row_idx);
    check_field("buf_adr", got.buf_adr, exp.buf_adr);
    check_field("buf_idx", 16'(got.buf_idx), 16'(exp.buf_idx));
    check_field("buf_word_select", 16'(got.buf_word_select), 16'(exp.buf_word_select));
    check_field("slab_adr", got.slab_adr, exp.slab_adr);
    check_field("slab_idx", 16'(got.slab_idx), 16'(exp.slab_idx));
    check_field("slab_adr_to_wr", got.slab_adr_to_wr, exp.slab_adr_to_wr);
    check_field("slab_idx_to_wr", 16'(got.slab_idx_to_wr), 16'(exp.slab_idx_to_wr));
    check_field("last", 16'(got.last), 16'(exp.last));
  endtask

  // Compare each accepted output against the predicted stream
  always @(posedge clk) begin
    if (rst_n && out_valid && out_ready) begin
      if (exp_q.size() == 0) begin
        errors++;
        $display("An output was accepted while no expected entry was pending");
      end else begin
        check_entry(out_data, exp_q.pop_front());
        seen++;
      end
    end
  end

  initial begin
    wait (watchdog_cycles > 0);
    repeat (watchdog_cycles) @(posedge clk);
    $display("Timeout after %0d cycles with %0d errors so far", watchdog_cycles, errors);
    $display("ERRORS FOUND");
    $finish;
  end

  initial begin
    int total;
    rst_n   = 1'b0;
    awaddr  = '0;
    awvalid = 1'b0;
    wdata   = '0;
    wstrb   = '0;
    wvalid  = 1'b0;
    bready  = 1'b0;
    araddr  = '0;
    arvalid = 1'b0;
    rready  = 1'b0;
    for (int i = 0; i < n_layers; i++) begin
      layers[i] = base_layer();
    end
    layers[1].s        = 4'd2;
    // Rows below p+1 and above p+iy, bias below, at and above zero
    layers[2].p        = 4'd3;
    layers[2].iy       = 16'd8;
    layers[2].iy_start_base = 16'd0;
    layers[2].poy      = 16'd3;
    layers[2].ky_num   = 4'd4;
    layers[2].row_base = 16'd0;
    layers[3].poy      = 16'd1;
    layers[4].slab_num = 4'd0;
    layers[5].s        = 4'd2;
    layers[5].iy       = 16'd64;
    layers[5].tile_num = 8'd10;
    layers[5].ky_num   = 4'd7;
    // Odd word of the input row
    layers[5].if_start = 16'd6;
    total = 0;
    for (int i = 0; i < n_layers; i++) begin
      total += int'(layers[i].tile_num) * int'(layers[i].ky_num);
    end
    watchdog_cycles = 200 * total + 2000;
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    for (int i = 0; i < n_layers; i++) begin
      run_layer(i, i != 0);
    end
    $display("Closing: %0d errors over %0d layers and %0d outputs", errors, n_layers, total);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

//--- sources.f
+incdir+.
conv_row_pkg.sv
conv_row_cfg_regs.sv
conv_row_sequencer.sv
conv_row_translate.sv
conv_row_result.sv
conv_row_top.sv
conv_row_tb_clk.sv
conv_row_tb.sv

//--- Makefile
TOP = conv_row_tb

.PHONY: build run clean

build:
	verilator --binary --timing -f sources.f --top-module $(TOP) --Mdir obj_dir -o $(TOP)_sim

run: build
	./obj_dir/$(TOP)_sim > sim.log 2>&1; cat sim.log
	grep -q "^NO ERRORS$$" sim.log

clean:
	rm -rf obj_dir sim.log
